// ==== src/rbuf_cfg.svh ====
`ifndef RBUF_CFG_SVH
`define RBUF_CFG_SVH

// Buffer entries, one per outstanding read
`define RBUF_ENTRIES 8

// Beats per DRAM burst
`define RBUF_BURST 8

// Ranks behind the PHY
`define RBUF_RANKS 4

// Width of one data beat on the DQ bus
`define RBUF_DATA_W 64

// Request ID width from the scheduler
`define RBUF_ID_W 8

`endif

// ==== src/rbufTypesPkg.sv ====
`include "rbuf_cfg.svh"

package rbufTypesPkg;

    // Index of one buffer entry
    typedef logic [$clog2(`RBUF_ENTRIES)-1:0] entryIdx;

    // One flag per buffer entry
    typedef logic [`RBUF_ENTRIES-1:0] entryVec;

    // Beat position inside a burst
    typedef logic [$clog2(`RBUF_BURST)-1:0] beatIdx;

    // Data memory address, entry in the upper bits and beat in the lower bits
    typedef logic [$clog2(`RBUF_ENTRIES*`RBUF_BURST)-1:0] slotAddr;

    // Rank number and per-rank flags
    typedef logic [$clog2(`RBUF_RANKS)-1:0] rankIdx;
    typedef logic [`RBUF_RANKS-1:0] rankVec;

    // Payload and request tag
    typedef logic [`RBUF_DATA_W-1:0] beatData;
    typedef logic [`RBUF_ID_W-1:0] reqId;

    // Occupancy, must also hold the full value
    typedef logic [$clog2(`RBUF_ENTRIES+1)-1:0] entryCount;

endpackage

// ==== src/rankWindowPkg.sv ====
package rankWindowPkg;

    import rbufTypesPkg::*;

    // Life of one window slot
    // Free until allocated, waiting for the PHY burst, received until served
    typedef enum logic [1:0] {
        slotFree     = 2'd0,
        slotWaiting  = 2'd1,
        slotReceived = 2'd2
    } slotState;

    // Two slots of one rank, each with the entry it points at
    typedef struct packed {
        slotState [1:0] state;
        entryIdx  [1:0] ptr;
    } windowSlots;

endpackage

// ==== src/requestDirectory.sv ====
`timescale 1ns/1ps

`include "rbuf_cfg.svh"

module requestDirectory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  allocValid,
    input  rbufTypesPkg::entryIdx allocEntry,
    input  rbufTypesPkg::reqId    allocId,
    input  rbufTypesPkg::rankIdx  allocRank,
    input  logic                  serveRead,
    input  rbufTypesPkg::entryIdx serveEntry,
    output rbufTypesPkg::reqId    readDataId,
    output rbufTypesPkg::rankIdx  serveRank
);

    import rbufTypesPkg::*;

    // ID and rank of each allocated entry
    reqId   idMem   [`RBUF_ENTRIES];
    rankIdx rankMem [`RBUF_ENTRIES];

    always_ff @(posedge clk) begin
        if (allocValid) begin
            idMem[allocEntry]   <= allocId;
            rankMem[allocEntry] <= allocRank;
        end
    end

    // ID follows each beat out, same latency as the data memory
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            readDataId <= '0;
        end else if (serveRead) begin
            readDataId <= idMem[serveEntry];
        end
    end

    // Rank needed in the release cycle itself
    assign serveRank = rankMem[serveEntry];

endmodule

// ==== src/burstDataBuffer.sv ====
`timescale 1ns/1ps

`include "rbuf_cfg.svh"

module burstDataBuffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  phyValid,
    input  logic                  phyLast,
    input  rbufTypesPkg::entryIdx phyEntry,
    input  rbufTypesPkg::beatData phyData,
    input  logic                  serveRead,
    input  rbufTypesPkg::entryIdx serveEntry,
    input  rbufTypesPkg::beatIdx  serveBeat,
    output rbufTypesPkg::beatData readData
);

    import rbufTypesPkg::*;

    // One burst slot of eight beats per entry
    beatData mem [`RBUF_ENTRIES * `RBUF_BURST];

    beatIdx  writeBeat;
    slotAddr writeAddr;
    slotAddr readAddr;

    assign writeAddr = {phyEntry, writeBeat};
    assign readAddr  = {serveEntry, serveBeat};

    // PHY beat position, gaps between beats allowed
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            writeBeat <= '0;
        end else if (phyValid) begin
            writeBeat <= phyLast ? beatIdx'(0) : writeBeat + beatIdx'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (phyValid) begin
            mem[writeAddr] <= phyData;
        end
        // Registered read, data lines up with readDataValid
        if (serveRead) begin
            readData <= mem[readAddr];
        end
    end

endmodule

// ==== src/rankWindow.sv ====
`timescale 1ns/1ps

`include "rbuf_cfg.svh"

module rankWindow (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  allocValid,
    input  rbufTypesPkg::rankIdx  allocRank,
    input  rbufTypesPkg::entryIdx allocEntry,
    input  logic                  phyValid,
    input  logic                  phyLast,
    input  rbufTypesPkg::rankIdx  phyTag,
    input  logic                  releaseValid,
    input  rbufTypesPkg::entryIdx releaseEntry,
    input  rbufTypesPkg::rankIdx  releaseRank,
    output rbufTypesPkg::entryIdx phyEntry,
    output logic                  doneValid,
    output rbufTypesPkg::entryIdx doneEntry,
    output rbufTypesPkg::rankVec  readRankWindowAvailable,
    output logic                  readBufferAvailable
);

    import rbufTypesPkg::*;
    import rankWindowPkg::*;

    ////////////////////
    // Window state
    ////////////////////

    // Two slots per rank
    windowSlots win [`RBUF_RANKS];
    // Per rank, which slot holds the older request
    rankVec head;

    windowSlots allocSlots;
    windowSlots phySlots;
    windowSlots relSlots;
    logic allocSlot;
    logic phySlot;
    logic relSlot;

    // Head slot is always occupied while the rank holds anything,
    // so a free head means both slots are free
    always_comb begin
        allocSlots = win[allocRank];
        if (allocSlots.state[head[allocRank]] == slotFree) begin
            allocSlot = head[allocRank];
        end else begin
            allocSlot = ~head[allocRank];
        end
    end

    // Oldest waiting slot of the tagged rank gets the PHY data
    // head may already be received and waiting on the cache
    always_comb begin
        phySlots = win[phyTag];
        if (phySlots.state[head[phyTag]] == slotWaiting) begin
            phySlot = head[phyTag];
        end else begin
            phySlot = ~head[phyTag];
        end
        phyEntry = phySlots.ptr[phySlot];
    end

    assign doneValid = phyValid && phyLast;
    assign doneEntry = phyEntry;

    // Released slot found by pointer match
    always_comb begin
        relSlots = win[releaseRank];
        relSlot  = (relSlots.state[1] == slotReceived) && (relSlots.ptr[1] == releaseEntry);
    end

    ////////////////////
    // Slot updates
    ////////////////////

    // Alloc, PHY last and release of one rank always touch different slots
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int r = 0; r < `RBUF_RANKS; r++) begin
                win[r] <= '0;
            end
            head <= '0;
        end else begin
            if (allocValid) begin
                win[allocRank].state[allocSlot] <= slotWaiting;
                win[allocRank].ptr[allocSlot]   <= allocEntry;
            end
            if (doneValid) begin
                win[phyTag].state[phySlot] <= slotReceived;
            end
            if (releaseValid) begin
                win[releaseRank].state[relSlot] <= slotFree;
                // Older one left, the other slot becomes the oldest
                if (relSlot == head[releaseRank]) begin
                    head[releaseRank] <= ~head[releaseRank];
                end
            end
        end
    end

    ////////////////////
    // Availability
    ////////////////////

    always_comb begin
        for (int r = 0; r < `RBUF_RANKS; r++) begin
            readRankWindowAvailable[r] = (win[r].state[0] == slotFree) ||
                                         (win[r].state[1] == slotFree);
        end
    end

    assign readBufferAvailable = |readRankWindowAvailable;

endmodule

// ==== src/bufferControl.sv ====
`timescale 1ns/1ps

`include "rbuf_cfg.svh"

module bufferControl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    allocValid,
    input  logic                    doneValid,
    input  rbufTypesPkg::entryIdx   doneEntry,
    input  logic                    readDataReady,
    input  rbufTypesPkg::rankIdx    serveRank,
    output rbufTypesPkg::entryIdx   allocEntry,
    output rbufTypesPkg::entryIdx   serveEntry,
    output rbufTypesPkg::beatIdx    serveBeat,
    output logic                    serveRead,
    output logic                    releaseValid,
    output rbufTypesPkg::entryIdx   releaseEntry,
    output rbufTypesPkg::rankIdx    releaseRank,
    output logic                    readDataValid,
    output logic                    readDataLast,
    output logic                    readBufferFull,
    output rbufTypesPkg::entryCount readBufferCnt
);

    import rbufTypesPkg::*;

    localparam beatIdx lastBeat = beatIdx'(`RBUF_BURST - 1);

    // Lowest set bit of an entry vector, zero when none is set
    function automatic entryIdx lowestSet(input entryVec vec);
        entryIdx idx;
        idx = '0;
        for (int i = `RBUF_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = entryIdx'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////
    // Entry tracking
    ////////////////////

    // Set bit means entry not allocated
    entryVec freeVec;
    // Set bit means whole burst is in the data memory
    entryVec recvVec;

    // Serve pointer stays locked on one entry for a whole burst
    logic    serveLock;
    entryIdx servePtr;
    entryIdx serveCand;
    logic    serveLastBeat;

    assign allocEntry = lowestSet(freeVec);
    assign serveCand  = lowestSet(recvVec);

    // Locked entry wins over a lower entry that just became ready
    assign serveEntry    = serveLock ? servePtr : serveCand;
    assign serveRead     = readDataReady && (serveLock || (|recvVec));
    assign serveLastBeat = (serveBeat == lastBeat);

    // Release once the eighth beat leaves the memory
    assign releaseValid = serveRead && serveLastBeat;
    assign releaseEntry = serveEntry;
    assign releaseRank  = serveRank;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            freeVec <= '1;
            recvVec <= '0;
        end else begin
            if (allocValid) begin
                freeVec[allocEntry] <= 1'b0;
            end
            // Last PHY beat seen at this edge
            if (doneValid) begin
                recvVec[doneEntry] <= 1'b1;
            end
            if (releaseValid) begin
                freeVec[releaseEntry] <= 1'b1;
                recvVec[releaseEntry] <= 1'b0;
            end
        end
    end

    ////////////////////
    // Serve sequencing
    ////////////////////

    // Beat counter only moves on a read, so back-pressure holds the position
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            serveLock     <= 1'b0;
            servePtr      <= '0;
            serveBeat     <= '0;
            readDataValid <= 1'b0;
            readDataLast  <= 1'b0;
        end else begin
            readDataValid <= serveRead;
            readDataLast  <= serveRead && serveLastBeat;
            if (serveRead) begin
                if (serveLastBeat) begin
                    serveLock <= 1'b0;
                    serveBeat <= '0;
                end else begin
                    serveLock <= 1'b1;
                    servePtr  <= serveEntry;
                    serveBeat <= serveBeat + beatIdx'(1);
                end
            end
        end
    end

    ////////////////////
    // Occupancy
    ////////////////////

    always_comb begin
        readBufferCnt = '0;
        for (int i = 0; i < `RBUF_ENTRIES; i++) begin
            if (!freeVec[i]) begin
                readBufferCnt = readBufferCnt + entryCount'(1);
            end
        end
    end

    // No free entry left
    assign readBufferFull = ~(|freeVec);

endmodule

// ==== src/readBufferTop.sv ====
`timescale 1ns/1ps

module readBufferTop (
    input  logic                   clk,
    input  logic                   rst,
    // Scheduler allocation
    input  logic                   allocValid,
    input  rbufTypesPkg::reqId     allocId,
    input  rbufTypesPkg::rankIdx   allocRank,
    // PHY read data
    input  logic                   phyValid,
    input  logic                   phyLast,
    input  rbufTypesPkg::rankIdx   phyTag,
    input  rbufTypesPkg::beatData  phyData,
    // Cache side
    input  logic                   readDataReady,
    output rbufTypesPkg::beatData  readData,
    output rbufTypesPkg::reqId     readDataId,
    output logic                   readDataValid,
    output logic                   readDataLast,
    // Status back to the scheduler
    output logic                   readBufferFull,
    output logic                   readBufferAvailable,
    output rbufTypesPkg::rankVec   readRankWindowAvailable,
    output rbufTypesPkg::entryCount readBufferCnt
);

    import rbufTypesPkg::*;

    ////////////////////
    // Internal wiring
    ////////////////////

    // Allocation target
    entryIdx allocEntry;

    // Serve path
    entryIdx serveEntry;
    beatIdx  serveBeat;
    logic    serveRead;
    rankIdx  serveRank;

    // Entry release after the last served beat
    logic    releaseValid;
    entryIdx releaseEntry;
    rankIdx  releaseRank;

    // PHY side matching
    entryIdx phyEntry;
    logic    doneValid;
    entryIdx doneEntry;

    ////////////////////
    // Blocks
    ////////////////////

    bufferControl control (
        .clk            (clk),
        .rst            (rst),
        .allocValid     (allocValid),
        .doneValid      (doneValid),
        .doneEntry      (doneEntry),
        .readDataReady  (readDataReady),
        .serveRank      (serveRank),
        .allocEntry     (allocEntry),
        .serveEntry     (serveEntry),
        .serveBeat      (serveBeat),
        .serveRead      (serveRead),
        .releaseValid   (releaseValid),
        .releaseEntry   (releaseEntry),
        .releaseRank    (releaseRank),
        .readDataValid  (readDataValid),
        .readDataLast   (readDataLast),
        .readBufferFull (readBufferFull),
        .readBufferCnt  (readBufferCnt)
    );

    rankWindow window (
        .clk                     (clk),
        .rst                     (rst),
        .allocValid              (allocValid),
        .allocRank               (allocRank),
        .allocEntry              (allocEntry),
        .phyValid                (phyValid),
        .phyLast                 (phyLast),
        .phyTag                  (phyTag),
        .releaseValid            (releaseValid),
        .releaseEntry            (releaseEntry),
        .releaseRank             (releaseRank),
        .phyEntry                (phyEntry),
        .doneValid               (doneValid),
        .doneEntry               (doneEntry),
        .readRankWindowAvailable (readRankWindowAvailable),
        .readBufferAvailable     (readBufferAvailable)
    );

    requestDirectory directory (
        .clk        (clk),
        .rst        (rst),
        .allocValid (allocValid),
        .allocEntry (allocEntry),
        .allocId    (allocId),
        .allocRank  (allocRank),
        .serveRead  (serveRead),
        .serveEntry (serveEntry),
        .readDataId (readDataId),
        .serveRank  (serveRank)
    );

    burstDataBuffer dataMem (
        .clk        (clk),
        .rst        (rst),
        .phyValid   (phyValid),
        .phyLast    (phyLast),
        .phyEntry   (phyEntry),
        .phyData    (phyData),
        .serveRead  (serveRead),
        .serveEntry (serveEntry),
        .serveBeat  (serveBeat),
        .readData   (readData)
    );

endmodule

// ==== verification/readBufferTbTasks.svh ====
////////////////////
// Stimulus tasks
////////////////////

// Every task starts and ends 2 ns after a rising edge

// Next drive point with a fresh ready value when ready is randomized
task automatic stepCycle();
    @(posedge clk);
    #2;
    if (randomReady) begin
        readDataReady = ($random(seed) & 1) != 0;
    end
endtask

// One scheduler allocation taken at the next edge
task automatic allocRead(input rankIdx rank, input reqId id);
    allocValid = 1'b1;
    allocId    = id;
    allocRank  = rank;
    stepCycle();
    allocValid = 1'b0;
    heldCnt++;
    // Window order per rank is allocation order
    rankIdQ[rank].push_back(id);
endtask

// Full PHY burst for the oldest waiting request of a rank
task automatic sendBurst(input rankIdx rank, input bit gaps);
    reqId    id;
    beatData beat;
    id = rankIdQ[rank].pop_front();
    for (int b = 0; b < `RBUF_BURST; b++) begin
        // Optional idle cycle before a beat
        if (gaps && (($random(seed) & 3) == 0)) begin
            phyValid = 1'b0;
            phyLast  = 1'b0;
            stepCycle();
        end
        beat     = {$random(seed), $random(seed)};
        phyValid = 1'b1;
        phyTag   = rank;
        phyData  = beat;
        phyLast  = (b == `RBUF_BURST - 1);
        // Burst served whole, so beats queue up in send order
        expData.push_back(beat);
        expId.push_back(id);
        stepCycle();
    end
    phyValid = 1'b0;
    phyLast  = 1'b0;
endtask

// Cache drain until the monitor has seen enough beats
task automatic waitBeats(input int target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while ((beatsSeen < target) && (cycles < limit)) begin
        stepCycle();
        cycles++;
    end
    if (beatsSeen < target) begin
        timeoutFail(what);
    end
endtask

// ==== verification/readBufferTb.sv ====
`timescale 1ns/1ps

`include "rbuf_cfg.svh"

module readBufferTb;

    import rbufTypesPkg::*;

    // DUT ports
    logic      clk;
    logic      rst;
    logic      allocValid;
    reqId      allocId;
    rankIdx    allocRank;
    logic      phyValid;
    logic      phyLast;
    rankIdx    phyTag;
    beatData   phyData;
    logic      readDataReady;
    beatData   readData;
    reqId      readDataId;
    logic      readDataValid;
    logic      readDataLast;
    logic      readBufferFull;
    logic      readBufferAvailable;
    rankVec    readRankWindowAvailable;
    entryCount readBufferCnt;

    // Run state
    integer seed;
    int     errCount;
    int     beatsSeen;
    int     testsRun;
    int     testsFailed;
    logic   randomReady;

    // Entries held in the buffer as the model counts them
    int     heldCnt;

    // Outstanding IDs per rank with the oldest first
    reqId    rankIdQ [`RBUF_RANKS][$];
    // Beats in the order the cache has to see them
    beatData expData [$];
    reqId    expId [$];

    readBufferTop uut (
        .clk                     (clk),
        .rst                     (rst),
        .allocValid              (allocValid),
        .allocId                 (allocId),
        .allocRank               (allocRank),
        .phyValid                (phyValid),
        .phyLast                 (phyLast),
        .phyTag                  (phyTag),
        .phyData                 (phyData),
        .readDataReady           (readDataReady),
        .readData                (readData),
        .readDataId              (readDataId),
        .readDataValid           (readDataValid),
        .readDataLast            (readDataLast),
        .readBufferFull          (readBufferFull),
        .readBufferAvailable     (readBufferAvailable),
        .readRankWindowAvailable (readRankWindowAvailable),
        .readBufferCnt           (readBufferCnt)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Immediate check of one value against its expected value
    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Outputs as they must look after reset or a full drain
    task automatic checkIdleState();
        checkValue("readDataValid", readDataValid, 0);
        checkValue("readDataLast", readDataLast, 0);
        checkValue("readBufferFull", readBufferFull, 0);
        checkValue("readBufferCnt", readBufferCnt, 0);
        checkValue("readRankWindowAvailable", readRankWindowAvailable, {`RBUF_RANKS{1'b1}});
        checkValue("readBufferAvailable", readBufferAvailable, 1);
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testsRun++;
        if (errCount > errsBefore) begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, name,
                     errCount - errsBefore);
        end else begin
            $display("Test %0d %s: ok", testsRun, name);
        end
    endtask

    task automatic timeoutFail(input string what);
        errCount++;
        $display("Timeout while waiting for %s", what);
    endtask

    `include "readBufferTbTasks.svh"

    ////////////////////
    // Cache side monitor
    ////////////////////

    // Sampled mid-cycle, away from the driving and capturing edges
    always @(negedge clk) begin
        if (rst && readDataValid) begin
            if (expData.size() == 0) begin
                errCount++;
                $display("Unexpected beat at t=%0t, nothing was pending", $time);
            end else begin
                checkValue("readData", readData, expData.pop_front());
                checkValue("readDataId", readDataId, expId.pop_front());
                // Last flag only on the eighth beat of a burst
                checkValue("readDataLast", readDataLast,
                           (beatsSeen % `RBUF_BURST) == (`RBUF_BURST - 1));
            end
            // Entry leaves the buffer with its eighth beat
            if ((beatsSeen % `RBUF_BURST) == (`RBUF_BURST - 1)) begin
                heldCnt--;
            end
            beatsSeen++;
        end
    end

    ////////////////////
    // Protocol checks
    ////////////////////

    // A stall cycle gives no beat in the next cycle
    stallCheck: assert property (@(posedge clk) disable iff (!rst)
        !readDataReady |=> !readDataValid)
        else begin
            errCount++;
            $display("[ERROR] t=%0t readDataValid got 1 expected 0", $time);
        end

    lastCheck: assert property (@(posedge clk) disable iff (!rst)
        readDataLast |-> readDataValid)
        else begin
            errCount++;
            $display("[ERROR] t=%0t readDataValid got 0 expected 1", $time);
        end

    // Occupancy follows the allocations and the served bursts
    cntCheck: assert property (@(posedge clk) disable iff (!rst)
        readBufferCnt == heldCnt)
        else begin
            errCount++;
            $display("[ERROR] t=%0t readBufferCnt got %0d expected %0d", $time,
                     $sampled(readBufferCnt), $sampled(heldCnt));
        end

    // Full exactly when every entry is taken
    fullCheck: assert property (@(posedge clk) disable iff (!rst)
        readBufferFull == (heldCnt == `RBUF_ENTRIES))
        else begin
            errCount++;
            $display("[ERROR] t=%0t readBufferFull got %0b expected %0b", $time,
                     $sampled(readBufferFull), $sampled(heldCnt) == `RBUF_ENTRIES);
        end

    // Eight window slots for eight entries, so some rank stays open until full
    availCheck: assert property (@(posedge clk) disable iff (!rst)
        readBufferAvailable == (heldCnt != `RBUF_ENTRIES))
        else begin
            errCount++;
            $display("[ERROR] t=%0t readBufferAvailable got %0b expected %0b", $time,
                     $sampled(readBufferAvailable), $sampled(heldCnt) != `RBUF_ENTRIES);
        end

    // Eight entries fill all eight window slots
    fullWindowCheck: assert property (@(posedge clk) disable iff (!rst)
        (heldCnt == `RBUF_ENTRIES) |-> (readRankWindowAvailable == '0))
        else begin
            errCount++;
            $display("[ERROR] t=%0t readRankWindowAvailable got %0h expected 0", $time,
                     $sampled(readRankWindowAvailable));
        end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int start;
        seed          = 32'h8c1e;
        clk           = 1'b0;
        rst           = 1'b0;
        allocValid    = 1'b0;
        allocId       = '0;
        allocRank     = '0;
        phyValid      = 1'b0;
        phyLast       = 1'b0;
        phyTag        = '0;
        phyData       = '0;
        readDataReady = 1'b1;
        randomReady   = 1'b0;
        errCount      = 0;
        beatsSeen     = 0;
        testsRun      = 0;
        testsFailed   = 0;
        heldCnt       = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;

        start = errCount;
        checkIdleState();
        reportTest("reset state", start);

        // One read on rank 1
        start = errCount;
        beatsSeen = 0;
        allocRead(1, 8'h21);
        checkValue("readBufferCnt", readBufferCnt, 1);
        sendBurst(1, 1'b0);
        waitBeats(8, 100, "single read burst");
        checkValue("readBufferCnt", readBufferCnt, 0);
        checkValue("pending beats", expData.size(), 0);
        reportTest("single read round trip", start);

        // Rank 2 data comes back before rank 0 data
        start = errCount;
        beatsSeen = 0;
        allocRead(0, 8'h30);
        allocRead(2, 8'h32);
        sendBurst(2, 1'b1);
        sendBurst(0, 1'b0);
        waitBeats(16, 200, "bursts on ranks 2 and 0");
        checkValue("pending beats", expData.size(), 0);
        checkIdleState();
        reportTest("tag matching across ranks", start);

        // Both slots of rank 3
        start = errCount;
        beatsSeen = 0;
        allocRead(3, 8'h41);
        allocRead(3, 8'h42);
        checkValue("readRankWindowAvailable[3]", readRankWindowAvailable[3], 0);
        checkValue("readBufferAvailable", readBufferAvailable, 1);
        sendBurst(3, 1'b1);
        sendBurst(3, 1'b0);
        waitBeats(16, 200, "two bursts on rank 3");
        checkValue("pending beats", expData.size(), 0);
        checkIdleState();
        reportTest("two reads on one rank", start);

        // Random ready during a gapped burst
        start = errCount;
        beatsSeen = 0;
        randomReady = 1'b1;
        allocRead(2, 8'h55);
        sendBurst(2, 1'b1);
        waitBeats(8, 300, "burst under back-pressure");
        randomReady   = 1'b0;
        readDataReady = 1'b1;
        checkValue("pending beats", expData.size(), 0);
        reportTest("back-pressure", start);

        // Two reads on every rank fill the buffer
        start = errCount;
        beatsSeen = 0;
        for (int i = 0; i < `RBUF_ENTRIES; i++) begin
            allocRead(rankIdx'(i % `RBUF_RANKS), reqId'(8'h60 + i));
        end
        checkValue("readBufferFull", readBufferFull, 1);
        checkValue("readBufferCnt", readBufferCnt, `RBUF_ENTRIES);
        checkValue("readRankWindowAvailable", readRankWindowAvailable, 0);
        checkValue("readBufferAvailable", readBufferAvailable, 0);
        for (int i = 0; i < `RBUF_ENTRIES; i++) begin
            sendBurst(rankIdx'(`RBUF_RANKS - 1 - (i % `RBUF_RANKS)), i[0]);
        end
        waitBeats(8 * `RBUF_ENTRIES, 600, "drain of a full buffer");
        checkValue("pending beats", expData.size(), 0);
        checkIdleState();
        reportTest("occupancy and full", start);

        repeat (2) @(posedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
+incdir+verification
src/rbufTypesPkg.sv
src/rankWindowPkg.sv
src/requestDirectory.sv
src/burstDataBuffer.sv
src/rankWindow.sv
src/bufferControl.sv
src/readBufferTop.sv
verification/readBufferTb.sv
